/* rtl/tcb_pkg.sv */
// shared TCB bus definitions for the arbiter project
// imported by the multiplexer, memory and top level

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  // address width in bits
  localparam int unsigned TCB_AW = 10;
  // data width in bits
  localparam int unsigned TCB_DW = 32;
  // one byte enable per data byte
  localparam int unsigned TCB_BW = TCB_DW / 8;

  ////////////////////////////////////////////////////////////
  // protocol
  ////////////////////////////////////////////////////////////

  // read response delay after the transfer edge, in cycles
  localparam int unsigned TCB_DLY = 1;

  // transfer opcode
  typedef enum logic {
    TCB_READ  = 1'b0,
    TCB_WRITE = 1'b1
  } tcb_op_t;

endpackage

/* rtl/tcb_arb_pkg.sv */
// arbitration mode and round robin pointer arithmetic
// used by the arbiter and top level

package tcb_arb_pkg;

  // grant policy
  typedef enum logic {
    ARB_FIXED = 1'b0,
    ARB_ROUND = 1'b1
  } arb_mode_t;

  // manager index at offset ofs from the pointer, wrapped at n
  // ptr and ofs are both below n, so one subtraction is enough
  function automatic int unsigned rr_index(int unsigned ptr, int unsigned ofs, int unsigned n);
    return (ptr + ofs >= n) ? ptr + ofs - n : ptr + ofs;
  endfunction

  // position after the winner, wrapped at n
  function automatic int unsigned rr_next(int unsigned ptr, int unsigned n);
    return (ptr + 1 >= n) ? 0 : ptr + 1;
  endfunction

endpackage

/* rtl/tcb_lib_arbiter.sv */
// grant selector for the TCB many-to-one interconnect
// fixed priority follows PRI, round robin starts at a rotating pointer
// sel is combinational from the valid levels, the pointer moves on xfr

`timescale 1ns/1ps

module tcb_lib_arbiter #(
  // number of managers
  parameter  int unsigned IFN = 3,
  localparam int unsigned IFL = (IFN > 1) ? $clog2(IFN) : 1,
  // grant policy
  parameter  tcb_arb_pkg::arb_mode_t MODE = tcb_arb_pkg::ARB_FIXED,
  // priority table, first entry wins first
  parameter  int unsigned PRI [IFN] = '{0, 1, 2}
) (
  input  logic           clk,
  input  logic           rst_n,
  // manager valid levels
  input  logic [IFN-1:0] vld,
  // a transfer completed this cycle
  input  logic           xfr,
  // granted manager
  output logic [IFL-1:0] sel
);

  import tcb_arb_pkg::*;

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  // round robin start position
  logic [IFL-1:0] ptr;
  // manager index for each priority slot
  logic [IFL-1:0] order [IFN];
  // valid levels in priority order
  logic [IFN-1:0] vld_ord;
  // first valid priority slot
  logic [IFL-1:0] first;

  ////////////////////////////////////////////////////////////
  // reorder and encode
  ////////////////////////////////////////////////////////////

  // slot i holds PRI[i] or the manager i places after the pointer
  always_comb begin
    for (int i = 0; i < IFN; i++) begin
      if (MODE == ARB_ROUND) begin
        order[i] = IFL'(rr_index(ptr, i, IFN));
      end else begin
        order[i] = IFL'(PRI[i]);
      end
      vld_ord[i] = vld[order[i]];
    end
  end

  // lowest valid slot wins
  // nothing valid gives slot 0, sel is then unused
  always_comb begin
    first = '0;
    for (int i = IFN - 1; i >= 0; i--) begin
      if (vld_ord[i]) begin
        first = IFL'(i);
      end
    end
  end

  // map the slot back to a manager index
  assign sel = order[first];

  ////////////////////////////////////////////////////////////
  // round robin pointer
  ////////////////////////////////////////////////////////////

  // winner drops to lowest priority after its transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (xfr && (MODE == ARB_ROUND)) begin
      ptr <= IFL'(rr_next(sel, IFN));
    end
  end

endmodule

/* rtl/tcb_lib_multiplexer.sv */
// routes the granted manager's request to the single subordinate
// and steers the delayed response back to the manager that issued it
// sel comes from the arbiter, xfr goes back to it

`timescale 1ns/1ps

module tcb_lib_multiplexer #(
  // number of managers
  parameter  int unsigned IFN = 3,
  localparam int unsigned IFL = (IFN > 1) ? $clog2(IFN) : 1
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // grant from the arbiter
  input  logic [IFL-1:0]                        sel,
  // manager side requests
  input  logic [IFN-1:0]                        man_vld,
  input  tcb_pkg::tcb_op_t [IFN-1:0]            man_op,
  input  logic [IFN-1:0][tcb_pkg::TCB_AW-1:0]   man_adr,
  input  logic [IFN-1:0][tcb_pkg::TCB_BW-1:0]   man_ben,
  input  logic [IFN-1:0][tcb_pkg::TCB_DW-1:0]   man_wdt,
  // manager side responses
  output logic [IFN-1:0]                        man_rdy,
  output logic [IFN-1:0][tcb_pkg::TCB_DW-1:0]   man_rdt,
  // subordinate side request
  output logic                                  sub_vld,
  output tcb_pkg::tcb_op_t                      sub_op,
  output logic [tcb_pkg::TCB_AW-1:0]            sub_adr,
  output logic [tcb_pkg::TCB_BW-1:0]            sub_ben,
  output logic [tcb_pkg::TCB_DW-1:0]            sub_wdt,
  // subordinate side response
  input  logic                                  sub_rdy,
  input  logic [tcb_pkg::TCB_DW-1:0]            sub_rdt,
  // transfer strobe for the arbiter
  output logic                                  xfr
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  // granted manager drives the subordinate
  assign sub_vld = man_vld[sel];
  assign sub_op  = man_op [sel];
  assign sub_adr = man_adr[sel];
  assign sub_ben = man_ben[sel];
  assign sub_wdt = man_wdt[sel];

  // ready only to the granted manager, and only while it asks
  always_comb begin
    man_rdy      = '0;
    man_rdy[sel] = sub_rdy & man_vld[sel];
  end

  // vld and rdy both high
  assign xfr = sub_vld & sub_rdy;

  ////////////////////////////////////////////////////////////
  // response delay line
  ////////////////////////////////////////////////////////////

  // one stage per cycle of subordinate latency
  logic [TCB_DLY-1:0] rsp_vld;
  logic [IFL-1:0]     rsp_sel [TCB_DLY];

  // response pending flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld <= '0;
    end else begin
      rsp_vld[0] <= xfr;
      for (int i = 1; i < TCB_DLY; i++) begin
        rsp_vld[i] <= rsp_vld[i-1];
      end
    end
  end

  // owner of each response in flight
  always_ff @(posedge clk) begin
    rsp_sel[0] <= sel;
    for (int i = 1; i < TCB_DLY; i++) begin
      rsp_sel[i] <= rsp_sel[i-1];
    end
  end

  // last stage picks the receiver, others read zero
  always_comb begin
    man_rdt = '0;
    if (rsp_vld[TCB_DLY-1]) begin
      man_rdt[rsp_sel[TCB_DLY-1]] = sub_rdt;
    end
  end

endmodule

/* rtl/tcb_lib_memory.sv */
// synchronous byte-enabled memory on a TCB subordinate port
// always ready, read data one cycle after the transfer edge

`timescale 1ns/1ps

module tcb_lib_memory #(
  // number of data words
  parameter int unsigned DEPTH = 256
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // request
  input  logic                       vld,
  input  tcb_pkg::tcb_op_t           op,
  input  logic [tcb_pkg::TCB_AW-1:0] adr,
  input  logic [tcb_pkg::TCB_BW-1:0] ben,
  input  logic [tcb_pkg::TCB_DW-1:0] wdt,
  // response
  output logic                       rdy,
  output logic [tcb_pkg::TCB_DW-1:0] rdt
);

  import tcb_pkg::*;

  // word index width, upper address bits are ignored
  localparam int unsigned AL = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  logic [TCB_DW-1:0] mem [DEPTH];
  logic [AL-1:0]     idx;
  logic              xfr;

  // never stalls
  assign rdy = 1'b1;

  assign xfr = vld & rdy;
  assign idx = adr[AL-1:0];

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  // only enabled bytes change, on the transfer edge
  always_ff @(posedge clk) begin
    if (xfr && (op == TCB_WRITE)) begin
      for (int b = 0; b < TCB_BW; b++) begin
        if (ben[b]) begin
          mem[idx][8*b+:8] <= wdt[8*b+:8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////

  // registered read, holds between reads
  // writes leave the last read data in place
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdt <= '0;
    end else if (xfr && (op == TCB_READ)) begin
      rdt <= mem[idx];
    end
  end

endmodule

/* rtl/tcb_arbiter_top.sv */
// many-to-one TCB interconnect with a shared on-chip memory
// managers connect through packed per-manager arrays
// all parameters are set here and passed down

`timescale 1ns/1ps

module tcb_arbiter_top #(
  parameter  int unsigned IFN = 3,
  localparam int unsigned IFL = (IFN > 1) ? $clog2(IFN) : 1,
  parameter  tcb_arb_pkg::arb_mode_t MODE = tcb_arb_pkg::ARB_FIXED,
  parameter  int unsigned PRI [IFN] = '{0, 1, 2},
  parameter  int unsigned DEPTH = 256
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // manager requests
  input  logic [IFN-1:0]                        man_vld,
  input  tcb_pkg::tcb_op_t [IFN-1:0]            man_op,
  input  logic [IFN-1:0][tcb_pkg::TCB_AW-1:0]   man_adr,
  input  logic [IFN-1:0][tcb_pkg::TCB_BW-1:0]   man_ben,
  input  logic [IFN-1:0][tcb_pkg::TCB_DW-1:0]   man_wdt,
  // manager responses
  output logic [IFN-1:0]                        man_rdy,
  output logic [IFN-1:0][tcb_pkg::TCB_DW-1:0]   man_rdt
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////////////////////////

  // arbiter and multiplexer
  logic [IFL-1:0]    sel;
  logic              xfr;
  // multiplexer to memory
  logic              sub_vld;
  tcb_op_t           sub_op;
  logic [TCB_AW-1:0] sub_adr;
  logic [TCB_BW-1:0] sub_ben;
  logic [TCB_DW-1:0] sub_wdt;
  logic              sub_rdy;
  logic [TCB_DW-1:0] sub_rdt;

  ////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////

  tcb_lib_arbiter #(
    .IFN  (IFN),
    .MODE (MODE),
    .PRI  (PRI)
  ) u_arbiter (
    .clk   (clk),
    .rst_n (rst_n),
    .vld   (man_vld),
    .xfr   (xfr),
    .sel   (sel)
  );

  tcb_lib_multiplexer #(
    .IFN (IFN)
  ) u_multiplexer (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel     (sel),
    .man_vld (man_vld),
    .man_op  (man_op),
    .man_adr (man_adr),
    .man_ben (man_ben),
    .man_wdt (man_wdt),
    .man_rdy (man_rdy),
    .man_rdt (man_rdt),
    .sub_vld (sub_vld),
    .sub_op  (sub_op),
    .sub_adr (sub_adr),
    .sub_ben (sub_ben),
    .sub_wdt (sub_wdt),
    .sub_rdy (sub_rdy),
    .sub_rdt (sub_rdt),
    .xfr     (xfr)
  );

  tcb_lib_memory #(
    .DEPTH (DEPTH)
  ) u_memory (
    .clk   (clk),
    .rst_n (rst_n),
    .vld   (sub_vld),
    .op    (sub_op),
    .adr   (sub_adr),
    .ben   (sub_ben),
    .wdt   (sub_wdt),
    .rdy   (sub_rdy),
    .rdt   (sub_rdt)
  );

endmodule

/* bench/tcb_arbiter_properties.sv */
// handshake and response assertions for the TCB interconnect
// attached to every tcb_arbiter_top instance by the bind below

`timescale 1ns/1ps

module tcb_arbiter_properties #(
  parameter int unsigned IFN = 3
) (
  input logic           clk,
  input logic           rst_n,
  input logic [IFN-1:0] man_vld,
  input logic [IFN-1:0] man_rdy,
  input logic           sub_vld
);

  ////////////////////////////////////////////////////////////
  // grant rules
  ////////////////////////////////////////////////////////////

  // single winner per cycle
  one_grant: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(man_rdy))
    else $error("more than one man_rdy high at once");

  // no ready without a request behind it
  rdy_needs_vld: assert property (@(posedge clk) disable iff (!rst_n)
    (man_rdy & ~man_vld) == '0)
    else $error("man_rdy high for a manager that is not valid");

  // bus quiet right after reset release
  idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !sub_vld)
    else $error("sub_vld high in the first cycle after reset");

endmodule

bind tcb_arbiter_top tcb_arbiter_properties #(
  .IFN (IFN)
) props (
  .clk     (clk),
  .rst_n   (rst_n),
  .man_vld (man_vld),
  .man_rdy (man_rdy),
  .sub_vld (sub_vld)
);

/* bench/tcb_arbiter_tb.sv */
// testbench for the TCB many-to-one interconnect with shared memory
// three managers issue random traffic, checked against a shadow memory
// and an arbitration model; MODE 0 is fixed priority, else round robin

`timescale 1ns/1ps

module tcb_arbiter_tb #(
  parameter int unsigned MODE = 0
);

  import tcb_pkg::*;
  import tcb_arb_pkg::*;

  ////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////

  localparam int unsigned IFN       = 3;
  localparam int unsigned DEPTH     = 256;
  localparam int unsigned AL        = $clog2(DEPTH);
  localparam int unsigned PRI [IFN] = '{2, 0, 1};
  localparam arb_mode_t   ARB_MODE  = (MODE != 0) ? ARB_ROUND : ARB_FIXED;

  // transfers per phase
  localparam int unsigned N_FILL = DEPTH;
  localparam int unsigned N_PAIR = 32;
  localparam int unsigned N_RAND = 200;
  localparam int unsigned N_BUSY = 30;
  localparam int unsigned TOTAL  = N_FILL + 2 * N_PAIR + IFN * (N_RAND + N_BUSY);
  localparam int unsigned LIMIT  = 2 * TOTAL + 100;

  typedef struct packed {
    tcb_op_t           op;
    logic [TCB_AW-1:0] adr;
    logic [TCB_BW-1:0] ben;
    logic [TCB_DW-1:0] wdt;
  } req_t;

  // expected response, data only meaningful for reads
  typedef struct packed {
    logic [31:0]       due;
    logic              rd;
    logic [TCB_DW-1:0] data;
  } rsp_t;

  ////////////////////////////////////////////////////////////
  // DUT and bench state
  ////////////////////////////////////////////////////////////

  logic                           clk;
  logic                           rst_n;
  logic [IFN-1:0]                 man_vld;
  tcb_op_t [IFN-1:0]              man_op;
  logic [IFN-1:0][TCB_AW-1:0]     man_adr;
  logic [IFN-1:0][TCB_BW-1:0]     man_ben;
  logic [IFN-1:0][TCB_DW-1:0]     man_wdt;
  logic [IFN-1:0]                 man_rdy;
  logic [IFN-1:0][TCB_DW-1:0]     man_rdt;

  logic [TCB_DW-1:0] shadow [DEPTH];
  req_t              req_q [IFN][$];
  rsp_t              rsp_q [IFN][$];
  logic [IFN-1:0]    granted = '0;
  logic              busy = 1'b0;
  int unsigned       ptr_model = 0;
  int unsigned       cycles = 0;
  int unsigned       errors = 0;
  int unsigned       issued [IFN] = '{default: 0};
  int unsigned       xfers [IFN] = '{default: 0};

  tcb_arbiter_top #(
    .IFN   (IFN),
    .MODE  (ARB_MODE),
    .PRI   (PRI),
    .DEPTH (DEPTH)
  ) dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .man_vld (man_vld),
    .man_op  (man_op),
    .man_adr (man_adr),
    .man_ben (man_ben),
    .man_wdt (man_wdt),
    .man_rdy (man_rdy),
    .man_rdt (man_rdt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [TCB_DW-1:0] exp,
                             input logic [TCB_DW-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  // every word differs, all address bits used
  function automatic logic [TCB_DW-1:0] fill_pattern(logic [7:0] a);
    return {a ^ 8'h5a, ~a, a + 8'h3c, a};
  endfunction

  function automatic req_t random_request();
    req_t r;
    r.op  = ($urandom_range(0, 1) != 0) ? TCB_WRITE : TCB_READ;
    r.adr = TCB_AW'($urandom);
    r.ben = TCB_BW'($urandom_range(1, (1 << TCB_BW) - 1));
    r.wdt = $urandom;
    return r;
  endfunction

  // first valid in PRI order, or first valid at or after ptr
  function automatic int unsigned model_grant(logic [IFN-1:0] vld, int unsigned ptr);
    int unsigned m;
    int unsigned win;
    bit          found;
    win = 0;
    found = 1'b0;
    for (int k = 0; k < IFN; k++) begin
      m = (ARB_MODE == ARB_ROUND) ? (ptr + k) % IFN : PRI[k];
      if (!found && vld[m]) begin
        win = m;
        found = 1'b1;
      end
    end
    return win;
  endfunction

  // byte-wise update, upper address bits dropped
  task automatic write_shadow(input logic [TCB_AW-1:0] adr, input logic [TCB_BW-1:0] ben,
                              input logic [TCB_DW-1:0] wdt);
    for (int b = 0; b < TCB_BW; b++) begin
      if (ben[b]) begin
        shadow[adr[AL-1:0]][8*b+:8] = wdt[8*b+:8];
      end
    end
  endtask

  // all queues drained and bus idle
  task automatic wait_idle();
    bit done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = (man_vld == '0);
      for (int i = 0; i < IFN; i++) begin
        if (req_q[i].size() != 0 || rsp_q[i].size() != 0) begin
          done = 1'b0;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // manager drivers
  ////////////////////////////////////////////////////////////

  initial begin
    req_t r;
    logic free;
    for (int i = 0; i < IFN; i++) begin
      man_vld[i] <= 1'b0;
      man_op[i]  <= TCB_READ;
      man_adr[i] <= '0;
      man_ben[i] <= '0;
      man_wdt[i] <= '0;
    end
    forever begin
      @(posedge clk);
      for (int i = 0; i < IFN; i++) begin
        // slot frees up on the grant edge
        free = !man_vld[i] || granted[i];
        if (free && req_q[i].size() != 0 && (busy || $urandom_range(0, 3) != 0)) begin
          r = req_q[i].pop_front();
          man_vld[i] <= 1'b1;
          man_op[i]  <= r.op;
          man_adr[i] <= r.adr;
          man_ben[i] <= r.ben;
          man_wdt[i] <= r.wdt;
          issued[i]++;
        end else if (free) begin
          man_vld[i] <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    logic [IFN-1:0] exp_rdy;
    int unsigned    win;
    rsp_t           rsp;
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", LIMIT);
      $display("Some tests failed");
      $finish;
    end else if (!rst_n) begin
      granted = '0;
      ptr_model = 0;
    end else begin
      // due response on its owner, zero on the rest
      for (int i = 0; i < IFN; i++) begin
        if (rsp_q[i].size() != 0 && rsp_q[i][0].due == cycles) begin
          rsp = rsp_q[i].pop_front();
          if (rsp.rd) begin
            check_value($sformatf("man_rdt[%0d]", i), rsp.data, man_rdt[i]);
          end
        end else begin
          check_value($sformatf("man_rdt[%0d]", i), '0, man_rdt[i]);
        end
      end
      // grant vs model
      exp_rdy = '0;
      win = model_grant(man_vld, ptr_model);
      if (man_vld != '0) begin
        exp_rdy[win] = 1'b1;
      end
      check_value("man_rdy", TCB_DW'(exp_rdy), TCB_DW'(man_rdy));
      granted = man_vld & man_rdy;
      // record transfers taken on the next edge
      for (int i = 0; i < IFN; i++) begin
        if (granted[i]) begin
          xfers[i]++;
          if (man_op[i] == TCB_WRITE) begin
            write_shadow(man_adr[i], man_ben[i], man_wdt[i]);
          end
          rsp.due  = cycles + 1;
          rsp.rd   = (man_op[i] == TCB_READ);
          rsp.data = shadow[man_adr[i][AL-1:0]];
          rsp_q[i].push_back(rsp);
        end
      end
      // winner moves to the back
      if (man_vld != '0 && ARB_MODE == ARB_ROUND) begin
        ptr_model = (win + 1) % IFN;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    req_t        r;
    int unsigned total_xfr;
    void'($urandom(32'hecf4114f));
    rst_n <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // a few idle cycles, no grant expected
    repeat (4) @(posedge clk);
    @(negedge clk);

    // single manager, fill then write and read back
    busy = 1'b1;
    for (int a = 0; a < N_FILL; a++) begin
      r.op  = TCB_WRITE;
      r.adr = TCB_AW'(a);
      r.ben = '1;
      r.wdt = fill_pattern(8'(a));
      req_q[0].push_back(r);
    end
    for (int k = 0; k < N_PAIR; k++) begin
      r = random_request();
      r.op = TCB_WRITE;
      req_q[0].push_back(r);
      r.op = TCB_READ;
      req_q[0].push_back(r);
    end
    wait_idle();

    // all managers, random valid levels
    busy = 1'b0;
    for (int i = 0; i < IFN; i++) begin
      for (int k = 0; k < N_RAND; k++) begin
        req_q[i].push_back(random_request());
      end
    end
    wait_idle();

    // all managers valid back to back
    busy = 1'b1;
    for (int i = 0; i < IFN; i++) begin
      for (int k = 0; k < N_BUSY; k++) begin
        req_q[i].push_back(random_request());
      end
    end
    wait_idle();
    @(posedge clk);

    // nothing lost or duplicated
    total_xfr = 0;
    for (int i = 0; i < IFN; i++) begin
      check_value($sformatf("transfers of manager %0d", i), issued[i], xfers[i]);
      total_xfr += xfers[i];
    end
    check_value("total transfers", TOTAL, total_xfr);

    $display("%0d errors in %0d transfers over %0d cycles", errors, total_xfr, cycles);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* tcb_arbiter.f */
rtl/tcb_pkg.sv
rtl/tcb_arb_pkg.sv
rtl/tcb_lib_arbiter.sv
rtl/tcb_lib_multiplexer.sv
rtl/tcb_lib_memory.sv
rtl/tcb_arbiter_top.sv
bench/tcb_arbiter_properties.sv
bench/tcb_arbiter_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the TCB arbiter bench once per arbitration mode
# mode 0 is fixed priority, mode 1 is round robin
cd "$(dirname "$0")" || exit 1
status=0
for mode in 0 1; do
  log="sim_mode$mode.log"
  rm -f "$log"
  verilator --binary --timing --assert -Wno-fatal --top-module tcb_arbiter_tb \
    -GMODE=$mode --Mdir "obj_mode$mode" -f tcb_arbiter.f &&
    "./obj_mode$mode/Vtcb_arbiter_tb" > "$log" 2>&1
  cat "$log" 2>/dev/null
  grep -q "All tests passed" "$log" 2>/dev/null && echo "mode $mode passed" ||
    { echo "mode $mode failed"; status=1; }
done
exit $status
